// File: audio_sampler.sv
`timescale 1ns/1ps

module audio_sampler import core_pkg::*; #(
	parameter int AUDIO_PERIOD = 2267
) (
	input  logic                 CLK,
	input  logic                 RESET_L,
	input  logic                 play,
	input  logic [SD_DATA_W-1:0] song_data,
	input  logic                 song_data_ready,
	output logic                 song_request_data,
	output logic [SD_DATA_W-1:0] audio_out,
	output logic                 audio_en
);

	localparam int CNT_W = (AUDIO_PERIOD > 1) ? $clog2(AUDIO_PERIOD) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(AUDIO_PERIOD - 1);

	logic [CNT_W-1:0] period_cnt;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			period_cnt        <= '0;
			song_request_data <= 1'b0;
			audio_out         <= '0;
		end else begin
			if (play) begin
				if (period_cnt == CNT_LAST)
					period_cnt <= '0;
				else
					period_cnt <= period_cnt + 1'b1;
			end
			song_request_data <= play && period_cnt == CNT_LAST; // one per period
			if (song_data_ready)
				audio_out <= song_data; // hold last sample
		end
	end

	assign audio_en = play;

endmodule

// File: base_addr_scanner.sv
`timescale 1ns/1ps

module base_addr_scanner import core_pkg::*; (
	input  logic          CLK,
	input  logic          RESET_L,
	input  logic          scan_start,
	input  beat_word_t    rd_data,
	output beat_addr_t    rd_addr,
	output logic          rd_en,
	output section_addr_t section_base,
	output section_addr_t section_size,
	output logic          scan_done
);

	localparam int SEC_W = $clog2(SECTION_COUNT);
	localparam logic [SEC_W-1:0] LAST_SEC = SEC_W'(SECTION_COUNT - 1);

	logic             running;
	logic [SEC_W-1:0] sec;      // section being read
	logic [1:0]       pat;      // cycle within the round
	beat_addr_t       hdr_addr;

	// header sits right after the previous section's body
	always_comb begin
		if (sec == '0)
			hdr_addr = '0;
		else
			hdr_addr = section_base[sec - 1'b1] + section_size[sec - 1'b1];
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			running      <= 1'b0;
			sec          <= '0;
			pat          <= '0;
			rd_addr      <= '0;
			rd_en        <= 1'b0;
			section_base <= '0;
			section_size <= '0;
			scan_done    <= 1'b0;
		end else begin
			scan_done <= running && pat == 2'd3 && sec == LAST_SEC;
			if (!running) begin
				if (scan_start) begin
					running <= 1'b1;
					sec     <= '0;
					pat     <= '0;
				end
			end else begin
				if (pat == 2'd0) begin
					rd_addr <= hdr_addr;
					rd_en   <= 1'b1;
				end else if (pat == 2'd3) begin
					// read data settled two cycles ago, safe to take
					section_size[sec] <= rd_data[BEAT_ADDR_W-1:0];
					section_base[sec] <= hdr_addr + 1'b1;
					rd_en             <= 1'b0;
					if (sec == LAST_SEC)
						running <= 1'b0;
					else
						sec <= sec + 1'b1;
				end
				pat <= pat + 1'b1;
			end
		end
	end

	// a new scan must find port B idle and no scan in flight
	a_start_when_idle: assert property (
		@(posedge CLK) disable iff (!RESET_L)
		scan_start |-> !running && !rd_en
	) else $error("scan_start while a scan is still running");

endmodule

// File: beatmap_loader.sv
`timescale 1ns/1ps

module beatmap_loader import core_pkg::*; (
	input  logic             CLK,
	input  logic             RESET_L,
	input  logic [7:0]       song_selection,
	input  logic             load_start,
	sd_stream_if.loader      sd,
	output beat_addr_t       wr_addr,
	output beat_word_t       wr_data,
	output logic             wr_en,
	output logic             load_done
);

	localparam int CNT_W = $clog2(BEAT_BYTES);
	localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(BEAT_BYTES - 1);

	typedef enum logic [1:0] {
		l_idle,
		l_req,  // issue one byte request
		l_wait  // request outstanding
	} ld_state_t;

	ld_state_t        state;
	logic [CNT_W-1:0] byte_cnt;
	beat_word_t       shift_q;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			state           <= l_idle;
			byte_cnt        <= '0;
			wr_addr         <= '0;
			wr_en           <= 1'b0;
			load_done       <= 1'b0;
			sd.restart      <= 1'b0;
			sd.request_data <= 1'b0;
			sd.init_index   <= '0;
		end else begin
			sd.restart      <= 1'b0;
			sd.request_data <= 1'b0;
			wr_en           <= 1'b0;
			load_done       <= 1'b0;
			if (wr_en)
				wr_addr <= wr_addr + 1'b1; // advance after each word
			case (state)
				l_idle: begin
					if (load_start) begin
						sd.restart    <= 1'b1;
						sd.init_index <= song_selection;
						byte_cnt      <= '0;
						wr_addr       <= '0;
						state         <= l_req;
					end
				end
				l_req: begin
					sd.request_data <= 1'b1;
					state           <= l_wait;
				end
				l_wait: begin
					if (sd.data_ready) begin
						if (byte_cnt == LAST_BYTE) begin
							byte_cnt <= '0;
							wr_en    <= 1'b1; // shift_q holds the full word now
						end else begin
							byte_cnt <= byte_cnt + 1'b1;
						end
						state <= l_req;
					end else if (sd.transmit_finished) begin
						load_done <= 1'b1;
						state     <= l_idle;
					end
				end
				default: state <= l_idle;
			endcase
		end
	end

	// first byte ends up most significant
	always_ff @(posedge CLK) begin
		if (state == l_wait && sd.data_ready)
			shift_q <= {shift_q[BEAT_DATA_W-SD_DATA_W-1:0], sd.data};
	end

	assign wr_data = shift_q;

	// the stream answers each request with exactly one byte
	a_no_stray_byte: assert property (
		@(posedge CLK) disable iff (!RESET_L)
		sd.data_ready |-> state == l_wait
	) else $error("data_ready without pending request");

endmodule

// File: core_pkg.sv
package core_pkg;

	// sequencer phases, in run order
	typedef enum logic [2:0] {
		s_init,
		s_load,    // start beatmap load
		s_w_load,
		s_scan,    // start section scan
		s_w_scan,
		s_play
	} phase_t;

	// beatmap BRAM geometry
	localparam int BEAT_ADDR_W = 13;
	localparam int BEAT_BYTES  = 3;
	localparam int SD_DATA_W   = 8; // one SD byte, also one audio sample
	localparam int BEAT_DATA_W = BEAT_BYTES * SD_DATA_W;

	// difficulty sections in one beatmap
	localparam int SECTION_COUNT = 4;

	typedef logic [BEAT_ADDR_W-1:0] beat_addr_t;
	typedef logic [BEAT_DATA_W-1:0] beat_word_t;

	// one entry per section, used for base and size tables
	typedef beat_addr_t [SECTION_COUNT-1:0] section_addr_t;

endpackage

// File: phase_fsm.sv
`timescale 1ns/1ps

module phase_fsm import core_pkg::*; (
	input  logic   CLK,
	input  logic   RESET_L,
	input  logic   load_done,
	input  logic   scan_done,
	output logic   load_start,
	output logic   scan_start,
	output logic   play,
	output phase_t phase
);

	phase_t next_phase;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			phase <= s_init;
		end else begin
			phase <= next_phase;
		end
	end

	always_comb begin
		case (phase)
			s_init:   next_phase = s_load;
			s_load:   next_phase = s_w_load;
			s_w_load: next_phase = load_done ? s_scan : s_w_load;
			s_scan:   next_phase = s_w_scan;
			s_w_scan: next_phase = scan_done ? s_play : s_w_scan;
			s_play:   next_phase = s_play; // stays until reset
			default:  next_phase = s_init;
		endcase
	end

	// start states last one cycle, so these are single pulses
	assign load_start = (phase == s_load);
	assign scan_start = (phase == s_scan);
	assign play       = (phase == s_play);

	// done pulses from the data modules must match the waiting phase
	a_load_done_phase: assert property (
		@(posedge CLK) disable iff (!RESET_L)
		load_done |-> phase == s_w_load
	) else $error("load_done outside s_w_load");

	a_scan_done_phase: assert property (
		@(posedge CLK) disable iff (!RESET_L)
		scan_done |-> phase == s_w_scan
	) else $error("scan_done outside s_w_scan");

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_song_core \
	-f song_core.f -o tb_song_core_sim > build.log 2>&1 \
	&& ./obj_dir/tb_song_core_sim > sim.log 2>&1
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sd_stream_if.sv
`timescale 1ns/1ps

interface sd_stream_if import core_pkg::*; ();

	logic [7:0]           init_index;        // file selector sent with restart
	logic                 restart;
	logic                 request_data;      // one byte per pulse
	logic [SD_DATA_W-1:0] data;
	logic                 data_ready;
	logic                 transmit_finished; // no more bytes

	modport loader (
		output init_index, restart, request_data,
		input  data, data_ready, transmit_finished
	);

	modport top (
		input  init_index, restart, request_data,
		output data, data_ready, transmit_finished
	);

endinterface

// File: song_core.f
core_pkg.sv
sd_stream_if.sv
phase_fsm.sv
beatmap_loader.sv
base_addr_scanner.sv
audio_sampler.sv
song_core.sv
tb_song_core.sv

// File: song_core.sv
`timescale 1ns/1ps

module song_core import core_pkg::*; #(
	parameter int AUDIO_PERIOD = 2267
) (
	input  logic                 CLK,
	input  logic                 RESET_L,
	input  logic [7:0]           song_selection,
	input  logic [SD_DATA_W-1:0] pre_data,
	input  logic                 pre_data_ready,
	input  logic                 pre_transmit_finished,
	input  logic [SD_DATA_W-1:0] song_data,
	input  logic                 song_data_ready,
	input  beat_word_t           db_b_data_out,
	output logic [7:0]           pre_init_index,
	output logic                 pre_restart,
	output logic                 pre_request_data,
	output beat_addr_t           db_a_addr,
	output beat_word_t           db_a_data_in,
	output logic                 db_a_en_w,
	output beat_addr_t           db_b_addr,
	output logic                 db_b_en,
	output section_addr_t        section_base,
	output section_addr_t        section_size,
	output logic                 song_request_data,
	output logic [SD_DATA_W-1:0] audio_out,
	output logic                 audio_en,
	output phase_t               phase
);

	logic load_start, load_done;
	logic scan_start, scan_done;
	logic play;

	sd_stream_if sd ();

	// SD byte stream to and from the pins
	assign sd.data              = pre_data;
	assign sd.data_ready        = pre_data_ready;
	assign sd.transmit_finished = pre_transmit_finished;
	assign pre_init_index       = sd.init_index;
	assign pre_restart          = sd.restart;
	assign pre_request_data     = sd.request_data;

	phase_fsm i_phase_fsm (
		.CLK        (CLK),
		.RESET_L    (RESET_L),
		.load_done  (load_done),
		.scan_done  (scan_done),
		.load_start (load_start),
		.scan_start (scan_start),
		.play       (play),
		.phase      (phase)
	);

	// port A only, written during load
	beatmap_loader i_beatmap_loader (
		.CLK            (CLK),
		.RESET_L        (RESET_L),
		.song_selection (song_selection),
		.load_start     (load_start),
		.sd             (sd.loader),
		.wr_addr        (db_a_addr),
		.wr_data        (db_a_data_in),
		.wr_en          (db_a_en_w),
		.load_done      (load_done)
	);

	// port B only, read during scan
	base_addr_scanner i_base_addr_scanner (
		.CLK          (CLK),
		.RESET_L      (RESET_L),
		.scan_start   (scan_start),
		.rd_data      (db_b_data_out),
		.rd_addr      (db_b_addr),
		.rd_en        (db_b_en),
		.section_base (section_base),
		.section_size (section_size),
		.scan_done    (scan_done)
	);

	audio_sampler #(
		.AUDIO_PERIOD (AUDIO_PERIOD)
	) i_audio_sampler (
		.CLK               (CLK),
		.RESET_L           (RESET_L),
		.play              (play),
		.song_data         (song_data),
		.song_data_ready   (song_data_ready),
		.song_request_data (song_request_data),
		.audio_out         (audio_out),
		.audio_en          (audio_en)
	);

endmodule

// File: tb_song_core.sv
`timescale 1ns/1ps

module tb_song_core import core_pkg::*; ();

	localparam int ROWS   = 3;
	localparam int PERIOD = 8;

	// per row: four section sizes, then one song sample
	int         size_tab [ROWS][SECTION_COUNT] = '{'{2, 3, 1, 4}, '{0, 5, 2, 1}, '{6, 0, 0, 3}};
	logic [7:0] sample_tab [ROWS] = '{8'h5a, 8'hc3, 8'h01};

	logic                 CLK, RESET_L;
	logic [7:0]           song_selection, pre_init_index;
	logic [SD_DATA_W-1:0] pre_data, song_data, audio_out;
	logic                 pre_data_ready, pre_transmit_finished, song_data_ready;
	logic                 pre_restart, pre_request_data, db_a_en_w, db_b_en;
	logic                 song_request_data, audio_en;
	beat_word_t           db_b_data_out, db_a_data_in;
	beat_addr_t           db_a_addr, db_b_addr, rd_addr_q;
	section_addr_t        section_base, section_size;
	phase_t               phase;

	logic [7:0] stream [1024]; // SD file bytes for the current row
	int         stream_len, byte_idx, restart_cnt, write_cnt;
	int         seed = 33212;
	beat_word_t mem [1 << BEAT_ADDR_W];
	logic       rd_pend;

	song_core #(.AUDIO_PERIOD(PERIOD)) i_song_core (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	task automatic abort_run(input string why);
		$display("Test failures found");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
			abort_run("stopped at first mismatch");
		end
	endtask

	task automatic append_word(input beat_word_t w);
		for (int b = BEAT_BYTES - 1; b >= 0; b--) begin
			stream[stream_len] = w[b*SD_DATA_W +: SD_DATA_W]; // first byte is the top one
			stream_len++;
		end
	endtask

	// beatmap BRAM, port B answers one cycle after the read
	always @(posedge CLK) begin
		#1;
		if (rd_pend)
			db_b_data_out = mem[rd_addr_q];
		rd_pend   = db_b_en;
		rd_addr_q = db_b_addr;
		if (db_a_en_w) begin
			check_value(db_a_addr, write_cnt, "write address");
			check_value(db_a_data_in, {stream[3*write_cnt], stream[3*write_cnt+1],
				stream[3*write_cnt+2]}, "write word");
			mem[db_a_addr] = db_a_data_in;
			write_cnt++;
		end
	end

	// SD source, one byte per request after 1 to 4 cycles
	always @(posedge CLK) begin
		int delay;
		#1;
		if (pre_restart) begin
			check_value(pre_init_index, song_selection, "init index on restart");
			restart_cnt++;
			byte_idx = 0;
		end
		if (pre_request_data && byte_idx < stream_len) begin
			delay = 1 + ($random(seed) & 3);
			repeat (delay) @(posedge CLK);
			#1;
			pre_data       = stream[byte_idx];
			pre_data_ready = 1'b1;
			@(posedge CLK);
			#1;
			pre_data_ready = 1'b0;
			byte_idx++;
			if (byte_idx == stream_len)
				pre_transmit_finished = 1'b1; // file is out of bytes
		end
	end

	task automatic check_idle();
		check_value({pre_restart, pre_request_data, db_a_en_w, db_b_en, song_request_data,
			audio_en}, '0, "control outputs idle");
		check_value(section_base, '0, "base table cleared");
		check_value(section_size, '0, "size table cleared");
		check_value(audio_out, '0, "audio_out cleared");
	endtask

	task automatic run_row(input int r);
		int exp_base;
		RESET_L               = 1'b0;
		song_selection        = 8'(33 + 16 * r);
		pre_data_ready        = 1'b0;
		pre_transmit_finished = 1'b0;
		song_data_ready       = 1'b0;
		stream_len            = 0;
		byte_idx              = 0;
		restart_cnt           = 0;
		write_cnt             = 0;
		for (int i = 0; i < SECTION_COUNT; i++) begin
			append_word(beat_word_t'(size_tab[r][i])); // section header
			for (int j = 0; j < size_tab[r][i]; j++)
				append_word({8'hb0 | 8'(r), 8'(i), 8'(j)});
		end
		repeat (3) begin
			@(posedge CLK);
			#1;
			check_idle();
			check_value(phase, s_init, "phase in reset");
		end
		RESET_L = 1'b1;
		@(posedge CLK);
		#1;
		check_idle(); // s_init done, load not yet started
		check_value(phase, s_load, "phase one cycle after reset");
		while (phase != s_play) begin
			@(posedge CLK);
			#1;
		end
		check_value(restart_cnt, 1, "restart pulses");
		check_value(write_cnt, stream_len / BEAT_BYTES, "words written");
		exp_base = 1;
		for (int i = 0; i < SECTION_COUNT; i++) begin
			check_value(section_size[i], size_tab[r][i], "section size");
			check_value(section_base[i], exp_base, "section base");
			exp_base = exp_base + size_tab[r][i] + 1;
		end
		for (int k = 0; k < 3; k++) begin
			for (int j = 0; j < PERIOD; j++) begin
				@(posedge CLK);
				#1;
				if (song_data_ready) begin
					song_data_ready = 1'b0;
					check_value(audio_out, song_data, "audio_out after sample");
				end
				check_value(audio_en, 1'b1, "audio_en in play");
				check_value(song_request_data, j == PERIOD - 1, "sample request timing");
			end
			if (k < 2) begin
				song_data       = (k == 0) ? sample_tab[r] : ~sample_tab[r];
				song_data_ready = 1'b1;
			end
		end
	endtask

	initial begin
		RESET_L               = 1'b0;
		song_selection        = '0;
		pre_data              = '0;
		pre_data_ready        = 1'b0;
		pre_transmit_finished = 1'b0;
		song_data             = '0;
		song_data_ready       = 1'b0;
		db_b_data_out         = '0;
		rd_pend               = 1'b0;
		for (int r = 0; r < ROWS; r++)
			run_row(r);
		$display("All tests passed!");
		$finish;
	end

	// watchdog sized from the stream length of every row
	initial begin
		int limit;
		limit = 0;
		for (int r = 0; r < ROWS; r++) begin
			limit += 200;
			for (int i = 0; i < SECTION_COUNT; i++)
				limit += (1 + size_tab[r][i]) * BEAT_BYTES * 6;
		end
		repeat (limit) @(posedge CLK);
		abort_run("watchdog expired before the last row finished");
	end

endmodule
